// File: Makefile
# Verilator build of the BTB testbench

SOURCES := $(shell cat flist.f)

.PHONY: all run clean

all: run

obj_dir/Vbtb_tb: flist.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps --top-module btb_tb \
		-f flist.f -o Vbtb_tb

sim.log: obj_dir/Vbtb_tb
	./obj_dir/Vbtb_tb > sim.log 2>&1 || true
	cat sim.log

run: sim.log
	@grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: flist.f
hdl/rv32i_types.sv
hdl/btb_pkg.sv
hdl/btb_array.sv
hdl/btb_way.sv
hdl/btb_select.sv
hdl/btb_datapath.sv
sim/btb_tb.sv

// File: hdl/btb_array.sv
/* Per-set storage, cleared on reset. rdata is registered on rd; wcur shows windex
   combinationally. A read and a write to the same set in one cycle read the old entry. */
`timescale 1ns/1ps
`default_nettype none

module btb_array #(
    parameter type entry_t = logic
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                rd,
    input  btb_pkg::btb_index_t rindex,
    input  logic                we,
    input  btb_pkg::btb_index_t windex,
    input  entry_t              wdata,
    output entry_t              rdata,
    output entry_t              wcur
);

    import btb_pkg::*;

    entry_t mem [num_sets];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < num_sets; i++)
            begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end
        else
        begin
            if (rd)
            begin
                rdata <= mem[rindex];  // old contents on same-cycle write
            end
            if (we)
            begin
                mem[windex] <= wdata;
            end
        end
    end

    assign wcur = mem[windex];  // used for update match and victim choice

endmodule : btb_array

`default_nettype wire

// File: hdl/btb_datapath.sv
/* Two-way BTB top. Lookup result is valid the cycle after the strobe;
   an update is visible to lookups from the next cycle on. No stalls. */
`timescale 1ns/1ps
`default_nettype none

module btb_datapath
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   lookup,
    input  rv32i_types::rv32i_word lookup_pc,
    input  btb_pkg::btb_update_t   update,
    output btb_pkg::btb_result_t   result
);

    import btb_pkg::*;

    btb_way_status_t status0;
    btb_way_status_t status1;
    logic            we0;
    logic            we1;

    btb_way way0 (
        .clk       (clk),
        .reset     (reset),
        .lookup    (lookup),
        .lookup_pc (lookup_pc),
        .update    (update),
        .we        (we0),
        .status    (status0)
    );

    btb_way way1 (
        .clk       (clk),
        .reset     (reset),
        .lookup    (lookup),
        .lookup_pc (lookup_pc),
        .update    (update),
        .we        (we1),
        .status    (status1)
    );

    btb_select select (
        .clk       (clk),
        .reset     (reset),
        .lookup    (lookup),
        .lookup_pc (lookup_pc),
        .update    (update),
        .status0   (status0),
        .status1   (status1),
        .we0       (we0),
        .we1       (we1),
        .result    (result)
    );

endmodule : btb_datapath

`default_nettype wire

// File: hdl/btb_pkg.sv
/* BTB geometry and payload structs. Two ways of 8 sets, one word per entry.
   Pc bits 1:0 are ignored, so compressed-instruction targets are not supported. */
`default_nettype none

package btb_pkg;

    import rv32i_types::*;

    localparam int s_offset = 2;                      // ignored low pc bits
    localparam int s_index  = 3;
    localparam int num_sets = 2**s_index;
    localparam int s_tag    = 32 - s_index - s_offset;

    typedef logic [s_index-1:0] btb_index_t;
    typedef logic [s_tag-1:0]   btb_tag_t;

    typedef struct packed {
        logic      valid;
        btb_tag_t  tag;
        rv32i_word target;
    } btb_entry_t;

    typedef struct packed {
        logic      en;      // one-cycle update strobe
        rv32i_word pc;
        rv32i_word target;
    } btb_update_t;

    typedef struct packed {
        logic      hit;     // level, valid the cycle after lookup
        rv32i_word target;
    } btb_result_t;

    typedef struct packed {
        logic      hit;
        rv32i_word target;
        logic      match;   // update pc already held here
    } btb_way_status_t;

endpackage : btb_pkg

`default_nettype wire

// File: hdl/btb_select.sv
/* Way combine, victim choice and one-bit LRU per set (bit names the victim way).
   The LRU has one write port: an update to any set takes it over a lookup-hit touch. */
`timescale 1ns/1ps
`default_nettype none

module btb_select
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     lookup,
    input  rv32i_types::rv32i_word   lookup_pc,
    input  btb_pkg::btb_update_t     update,
    input  btb_pkg::btb_way_status_t status0,
    input  btb_pkg::btb_way_status_t status1,
    output logic                     we0,
    output logic                     we1,
    output btb_pkg::btb_result_t     result
);

    import btb_pkg::*;

    btb_index_t lookup_index_q;
    btb_index_t update_index;
    btb_index_t lru_index;
    logic       lru_cur;
    logic       lru_we;
    logic       lru_wdata;

    assign update_index = update.pc[s_offset +: s_index];

    always_ff @(posedge clk)
    begin
        if (lookup)
            lookup_index_q <= lookup_pc[s_offset +: s_index];
    end

    // hit ways never overlap since no pc is held twice
    assign result.hit    = status0.hit || status1.hit;
    assign result.target = status0.hit ? status0.target : status1.target;

    // matching way first, else the LRU victim
    always_comb
    begin
        we0 = 1'b0;
        we1 = 1'b0;
        if (update.en)
        begin
            if (status0.match)
                we0 = 1'b1;
            else if (status1.match)
                we1 = 1'b1;
            else if (!lru_cur)
                we0 = 1'b1;
            else
                we1 = 1'b1;
        end
    end

    // update wins the port, else touch the hit set
    assign lru_index = update.en ? update_index : lookup_index_q;
    assign lru_we    = update.en || result.hit;
    assign lru_wdata = update.en ? we0 : status0.hit;  // point at the other way

    btb_array #(.entry_t(logic)) lru_array (
        .clk    (clk),
        .reset  (reset),
        .rd     (1'b0),            // only the write-side view is needed
        .rindex (lookup_index_q),
        .we     (lru_we),
        .windex (lru_index),
        .wdata  (lru_wdata),
        .rdata  (),
        .wcur   (lru_cur)
    );

endmodule : btb_select

`default_nettype wire

// File: hdl/btb_way.sv
/* One BTB way: entry array plus tag compares for lookup and update.
   status.hit is only asserted in the cycle right after a lookup strobe. */
`timescale 1ns/1ps
`default_nettype none

module btb_way
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     lookup,
    input  rv32i_types::rv32i_word   lookup_pc,
    input  btb_pkg::btb_update_t     update,
    input  logic                     we,
    output btb_pkg::btb_way_status_t status
);

    import btb_pkg::*;

    btb_index_t lookup_index;
    btb_index_t update_index;
    btb_tag_t   lookup_tag;
    btb_tag_t   lookup_tag_q;
    btb_tag_t   update_tag;
    logic       lookup_q;
    btb_entry_t wdata;
    btb_entry_t rdata;
    btb_entry_t wcur;

    assign lookup_index = lookup_pc[s_offset +: s_index];
    assign lookup_tag   = lookup_pc[s_offset + s_index +: s_tag];
    assign update_index = update.pc[s_offset +: s_index];
    assign update_tag   = update.pc[s_offset + s_index +: s_tag];

    assign wdata = '{valid: 1'b1, tag: update_tag, target: update.target};

    always_ff @(posedge clk)
    begin
        if (reset)
            lookup_q <= 1'b0;
        else
            lookup_q <= lookup;
    end

    always_ff @(posedge clk)
    begin
        if (lookup)
            lookup_tag_q <= lookup_tag;  // lines up with registered read
    end

    btb_array #(.entry_t(btb_entry_t)) entries (
        .clk    (clk),
        .reset  (reset),
        .rd     (lookup),
        .rindex (lookup_index),
        .we     (we),
        .windex (update_index),
        .wdata  (wdata),
        .rdata  (rdata),
        .wcur   (wcur)
    );

    assign status.hit    = lookup_q && rdata.valid && (rdata.tag == lookup_tag_q);
    assign status.target = rdata.target;
    assign status.match  = update.en && wcur.valid && (wcur.tag == update_tag);

endmodule : btb_way

`default_nettype wire

// File: hdl/rv32i_types.sv
/* ISA-level types shared by the fetch-side blocks.
   Only the 32-bit word is defined here; no compressed encodings. */
`default_nettype none

package rv32i_types;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] rv32i_word;  // pc, target

endpackage : rv32i_types

`default_nettype wire

// File: sim/btb_tb.sv
/* Table-driven testbench for the two-way BTB. Rows run one per cycle, with an idle
   cycle after each lookup. Expected values follow the way-choice and LRU rules. */
`timescale 1ns/1ps
`default_nettype none

module btb_tb;

    import rv32i_types::*;
    import btb_pkg::*;

    localparam logic [1:0] op_lookup = 2'd0;
    localparam logic [1:0] op_update = 2'd1;
    localparam logic [1:0] op_both   = 2'd2;  // lookup and update in one cycle

    typedef struct packed {
        logic [1:0]  op;
        rv32i_word   pc;
        rv32i_word   target;
        btb_result_t exp;
    } stim_row_t;

    logic        clk;
    logic        reset;
    logic        lookup;
    rv32i_word   lookup_pc;
    btb_update_t update;
    btb_result_t result;

    stim_row_t rows[$];
    int        checks;
    int        errors;

    btb_datapath uut (
        .clk       (clk),
        .reset     (reset),
        .lookup    (lookup),
        .lookup_pc (lookup_pc),
        .update    (update),
        .result    (result)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial
    begin
        #20000;
        $display("timeout: the run did not reach its end in time");
        $display("sim failed");
        $finish;
    end

    task automatic add_row(input logic [1:0] op, input rv32i_word pc, input rv32i_word target,
                           input logic exp_hit, input rv32i_word exp_target);
        stim_row_t row;
        row.op         = op;
        row.pc         = pc;
        row.target     = target;
        row.exp.hit    = exp_hit;
        row.exp.target = exp_target;
        rows.push_back(row);
    endtask

    task automatic check_result(input btb_result_t got, input btb_result_t exp,
                                input string what);
        checks++;
        if (got.hit !== exp.hit)
        begin
            errors++;
            $display("FAILED %0t: %s hit %0b, expected %0b", $time, what, got.hit, exp.hit);
        end
        else if (exp.hit && (got.target !== exp.target))
        begin
            errors++;
            $display("FAILED %0t: %s target %h, expected %h", $time, what, got.target,
                     exp.target);
        end
    endtask

    task automatic drive_row(input stim_row_t row);
        lookup    <= (row.op != op_update);
        lookup_pc <= row.pc;
        update    <= '{en: (row.op != op_lookup), pc: row.pc, target: row.target};
    endtask

    task automatic drive_idle();
        lookup    <= 1'b0;
        update.en <= 1'b0;
    endtask

    task automatic wait_result_clear(input int limit);
        int n;
        n = 0;
        while ((result.hit !== 1'b0) && (n < limit))
        begin
            @(posedge clk);
            n++;
        end
        if (result.hit !== 1'b0)
        begin
            errors++;
            $display("timeout: result.hit did not clear after reset");
        end
    endtask

    task automatic apply_row(input stim_row_t row, input int idx);
        @(posedge clk);
        drive_row(row);
        @(negedge clk);
        check_result(result, '0, $sformatf("row %0d, no lookup before", idx));
        if (row.op != op_update)
        begin
            @(posedge clk);
            drive_idle();
            @(negedge clk);
            check_result(result, row.exp, $sformatf("row %0d, lookup %h", idx, row.pc));
        end
    endtask

    task automatic load_table();
        // empty buffer after reset
        add_row(op_lookup, 32'h0000_1000, 32'h0, 1'b0, 32'h0);
        add_row(op_lookup, 32'h0000_100C, 32'h0, 1'b0, 32'h0);
        add_row(op_lookup, 32'h8000_0004, 32'h0, 1'b0, 32'h0);
        // set 3, A goes to way 0; low pc bits ignored
        add_row(op_update, 32'h0000_100C, 32'h0000_4000, 1'b0, 32'h0);
        add_row(op_lookup, 32'h0000_100C, 32'h0, 1'b1, 32'h0000_4000);
        add_row(op_lookup, 32'h0000_100F, 32'h0, 1'b1, 32'h0000_4000);
        add_row(op_update, 32'h0000_0010, 32'h0000_0550, 1'b0, 32'h0);
        add_row(op_lookup, 32'h0000_0012, 32'h0, 1'b1, 32'h0000_0550);
        // B fills way 1, both held
        add_row(op_update, 32'h0000_200C, 32'h0000_5000, 1'b0, 32'h0);
        add_row(op_lookup, 32'h0000_200C, 32'h0, 1'b1, 32'h0000_5000);
        add_row(op_lookup, 32'h0000_100C, 32'h0, 1'b1, 32'h0000_4000);
        // A touched last, so C evicts B
        add_row(op_update, 32'h0000_300C, 32'h0000_6000, 1'b0, 32'h0);
        add_row(op_lookup, 32'h0000_200C, 32'h0, 1'b0, 32'h0);
        add_row(op_lookup, 32'h0000_300C, 32'h0, 1'b1, 32'h0000_6000);
        add_row(op_lookup, 32'h0000_100C, 32'h0, 1'b1, 32'h0000_4000);  // C now the victim
        // A rewritten in place, not into the victim way
        add_row(op_update, 32'h0000_100C, 32'h0000_7000, 1'b0, 32'h0);
        add_row(op_lookup, 32'h0000_100C, 32'h0, 1'b1, 32'h0000_7000);
        add_row(op_lookup, 32'h0000_300C, 32'h0, 1'b1, 32'h0000_6000);
        // same-cycle lookup sees old C
        add_row(op_both,   32'h0000_300C, 32'h0000_8000, 1'b1, 32'h0000_6000);
        add_row(op_lookup, 32'h0000_300C, 32'h0, 1'b1, 32'h0000_8000);
        add_row(op_lookup, 32'h0000_100C, 32'h0, 1'b1, 32'h0000_7000);
    endtask

    initial
    begin
        checks    = 0;
        errors    = 0;
        reset     = 1'b1;
        lookup    = 1'b0;
        lookup_pc = '0;
        update    = '0;
        load_table();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        wait_result_clear(8);
        for (int i = 0; i < rows.size(); i++)
        begin
            apply_row(rows[i], i);
        end
        @(posedge clk);
        drive_idle();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule : btb_tb

`default_nettype wire
